//--- logic/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

`define XLEN        32
`define REG_ADDR_W  5

// opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OPIMM   7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

`define F3_ADD      3'b000
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_SW       3'b010

`define F7_SUB      5   // bit index inside funct7

`define CTRL_START_BIT      0
`define CTRL_RESET_BIT      1
`define FINISH_HOLD_CYCLES  30

`endif

//--- logic/rv_pkg.sv
package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, read through whichever layout its opcode calls for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

//--- logic/core_ifs.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

// decoded fields, from the ID stage into the ID->EX register
interface decode_if;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm;
    logic                   is_alu_reg;
    logic                   is_alu_imm;
    logic                   is_lui;
    logic                   is_store;
    logic                   is_branch;
    logic                   is_jal;
    logic [2:0]             funct3;
    logic                   sub;

    modport producer (output rd, rs1, rs2, imm, is_alu_reg, is_alu_imm, is_lui,
                      is_store, is_branch, is_jal, funct3, sub);
    modport consumer (input rd, rs1, rs2, imm, is_alu_reg, is_alu_imm, is_lui,
                      is_store, is_branch, is_jal, funct3, sub);
endinterface

// results still in flight in MEM and WB
interface wb_bus_if;
    logic [`REG_ADDR_W-1:0] mem_rd;
    logic                   mem_we;
    logic [`XLEN-1:0]       mem_data;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic                   wb_we;
    logic [`XLEN-1:0]       wb_data;

    modport source  (output mem_rd, mem_we, mem_data, wb_rd, wb_we, wb_data);
    modport write   (input wb_rd, wb_we, wb_data);
    modport forward (input mem_rd, mem_we, mem_data, wb_rd, wb_we, wb_data);
endinterface

//--- logic/decoder.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module decoder
    import rv_pkg::*;
(
    input  instr_u             instr_i,
    decode_if.producer         dec
);

    logic f7_ok;
    logic op_ok;
    logic opimm_ok;

    // funct7 is zero, or only the sub bit on an ADD
    assign f7_ok    = (instr_i.r.funct7 & ~(7'd1 << `F7_SUB)) == 7'd0 &&
                      (!instr_i.r.funct7[`F7_SUB] || instr_i.r.funct3 == `F3_ADD);
    assign op_ok    = f7_ok && instr_i.r.funct3 inside
                      {`F3_ADD, `F3_SLT, `F3_XOR, `F3_OR, `F3_AND};
    assign opimm_ok = instr_i.i.funct3 inside {`F3_ADD, `F3_XOR, `F3_OR, `F3_AND};

    always_comb begin
        dec.rd         = instr_i.r.rd;
        dec.rs1        = instr_i.r.rs1;
        dec.rs2        = instr_i.r.rs2;
        dec.funct3     = instr_i.r.funct3;
        dec.sub        = 1'b0;
        dec.imm        = '0;
        dec.is_alu_reg = 1'b0;
        dec.is_alu_imm = 1'b0;
        dec.is_lui     = 1'b0;
        dec.is_store   = 1'b0;
        dec.is_branch  = 1'b0;
        dec.is_jal     = 1'b0;
        case (instr_i.r.opcode)
            `OPC_OP: begin
                dec.is_alu_reg = op_ok;
                dec.sub        = instr_i.r.funct7[`F7_SUB];
            end
            `OPC_OPIMM: begin
                dec.is_alu_imm = opimm_ok;
                dec.imm        = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
            end
            `OPC_LUI: begin
                dec.is_lui = 1'b1;
                dec.imm    = {instr_i.u.imm, 12'd0};
            end
            `OPC_STORE: begin
                dec.is_store = instr_i.s.funct3 == `F3_SW;
                dec.imm      = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
            end
            `OPC_BRANCH: begin
                dec.is_branch = instr_i.b.funct3 inside {`F3_BEQ, `F3_BNE};
                dec.imm       = {{20{instr_i.b.imm12}}, instr_i.b.imm11, instr_i.b.imm10_5,
                                 instr_i.b.imm4_1, 1'b0};
            end
            `OPC_JAL: begin
                dec.is_jal = 1'b1;
                dec.imm    = {{12{instr_i.j.imm20}}, instr_i.j.imm19_12, instr_i.j.imm11,
                              instr_i.j.imm10_1, 1'b0};
            end
            default: ;                                  // unknown word, bubble
        endcase
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`REG_ADDR_W-1:0]  rs1_i,
    input  logic [`REG_ADDR_W-1:0]  rs2_i,
    wb_bus_if.write                 wr,
    output logic [`XLEN-1:0]        rs1_data_o,
    output logic [`XLEN-1:0]        rs2_data_o
);

    logic [`XLEN-1:0] regs [1:31];   // x0 is not stored

    always_ff @(posedge clk) begin
        if (!reset && wr.wb_we && wr.wb_rd != '0)
            regs[wr.wb_rd] <= wr.wb_data;
    end

    // a read of the register written this cycle sees the new value
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (wr.wb_we && wr.wb_rd == rs1_i) ? wr.wb_data : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (wr.wb_we && wr.wb_rd == rs2_i) ? wr.wb_data : regs[rs2_i];

endmodule

//--- logic/execute.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module execute (
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`REG_ADDR_W-1:0]  rd_i,
    input  logic [`REG_ADDR_W-1:0]  rs1_i,
    input  logic [`REG_ADDR_W-1:0]  rs2_i,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`XLEN-1:0]        rs2_data_i,
    input  logic [`XLEN-1:0]        imm_i,
    input  logic [2:0]              funct3_i,
    input  logic                    sub_i,
    input  logic                    is_alu_reg_i,
    input  logic                    is_alu_imm_i,
    input  logic                    is_lui_i,
    input  logic                    is_store_i,
    input  logic                    is_branch_i,
    input  logic                    is_jal_i,
    wb_bus_if.forward               fwd,
    output logic [`XLEN-1:0]        result_o,
    output logic [`XLEN-1:0]        store_data_o,
    output logic [`XLEN-1:0]        target_o,
    output logic                    taken_o,
    output logic                    reg_write_o
);

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu;
    logic             equal;

    // youngest result wins, x0 is never forwarded
    function automatic logic [`XLEN-1:0] pick(input logic [`REG_ADDR_W-1:0] rs,
                                              input logic [`XLEN-1:0] latched);
        if (rs == '0)
            return latched;
        if (fwd.mem_we && fwd.mem_rd == rs)
            return fwd.mem_data;
        if (fwd.wb_we && fwd.wb_rd == rs)
            return fwd.wb_data;
        return latched;
    endfunction

    assign rs1_val = pick(rs1_i, rs1_data_i);
    assign rs2_val = pick(rs2_i, rs2_data_i);
    assign op_b    = is_alu_imm_i ? imm_i : rs2_val;

    always_comb begin
        case (funct3_i)
            `F3_ADD: alu = sub_i ? rs1_val - op_b : rs1_val + op_b;
            `F3_SLT: alu = {{(`XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            `F3_XOR: alu = rs1_val ^ op_b;
            `F3_OR:  alu = rs1_val | op_b;
            `F3_AND: alu = rs1_val & op_b;
            default: alu = rs1_val + op_b;
        endcase
    end

    always_comb begin
        if (is_jal_i)
            result_o = pc_i + 32'd4;          // link value
        else if (is_lui_i)
            result_o = imm_i;
        else if (is_store_i)
            result_o = rs1_val + imm_i;       // effective address
        else
            result_o = alu;
    end

    assign equal        = rs1_val == rs2_val;
    assign taken_o      = is_jal_i | (is_branch_i & ((funct3_i == `F3_BNE) ? ~equal : equal));
    assign target_o     = pc_i + imm_i;
    assign store_data_o = rs2_val;
    assign reg_write_o  = (is_alu_reg_i | is_alu_imm_i | is_lui_i | is_jal_i) && rd_i != '0;

endmodule

//--- logic/run_control.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module run_control (
    input  logic              clk,
    input  logic              reset,
    input  logic [`XLEN-1:0]  ctrl_word_i,
    input  logic [`XLEN-1:0]  success_code_i,
    input  logic [`XLEN-1:0]  final_value_i,
    output logic              core_reset_o,
    output logic              core_enable_o,
    output logic              stop_o
);

    logic [`XLEN-1:0] ctrl_prev;
    logic [`XLEN-1:0] ctrl_pulse;
    logic [`XLEN-1:0] match_count;
    logic             enable_q;
    logic             stop_q;

    // rising edges of the control word, one cycle late
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_prev  <= '0;
            ctrl_pulse <= '0;
        end else begin
            ctrl_pulse <= ctrl_word_i & ~ctrl_prev;
            ctrl_prev  <= ctrl_word_i;
        end
    end

    assign core_reset_o = reset | ctrl_pulse[`CTRL_RESET_BIT];

    always_ff @(posedge clk) begin
        if (core_reset_o) begin
            enable_q    <= 1'b0;
            match_count <= '0;
            stop_q      <= 1'b0;
        end else begin
            if (ctrl_pulse[`CTRL_START_BIT])
                enable_q <= 1'b1;                // core runs on after stop
            if (final_value_i == success_code_i)
                match_count <= match_count + 1'b1;
            if (match_count >= `FINISH_HOLD_CYCLES)
                stop_q <= 1'b1;
        end
    end

    assign core_enable_o = enable_q;
    assign stop_o        = stop_q;

    stop_sticky: assert property (@(posedge clk) stop_o && !core_reset_o |=> stop_o);

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              enable_i,
    input  logic [`XLEN-1:0]  initial_pc_i,
    input  logic [`XLEN-1:0]  mem_offset_i,
    output logic              ins_mem_enb_o,
    output logic [`XLEN-1:0]  ins_mem_addrb_o,
    input  logic [`XLEN-1:0]  ins_mem_doutb_i,
    output logic              data_mem_enb_o,
    output logic [3:0]        data_mem_web_o,
    output logic [`XLEN-1:0]  data_mem_addrb_o,
    output logic [`XLEN-1:0]  data_mem_dinb_o,
    input  logic              data_mem_rstb_busy_i,
    output logic [`XLEN-1:0]  final_value_o
);

    decode_if dec_bus ();
    wb_bus_if wb_bus ();

    logic                   advance;
    logic [`XLEN-1:0]       pc;
    logic                   flush_q;
    logic [`XLEN-1:0]       if_pc;
    instr_u                 id_word;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    // ID->EX
    logic [`XLEN-1:0]       de_pc, de_rs1_data, de_rs2_data, de_imm;
    logic [`REG_ADDR_W-1:0] de_rd, de_rs1, de_rs2;
    logic [2:0]             de_funct3;
    logic                   de_sub;
    logic                   de_alu_reg, de_alu_imm, de_lui, de_store, de_branch, de_jal;
    // execute outputs and EX->MEM
    logic [`XLEN-1:0]       ex_result, ex_store_data, ex_target;
    logic                   ex_taken, ex_we;
    logic [`XLEN-1:0]       em_result, em_store_data, em_target;
    logic [`REG_ADDR_W-1:0] em_rd;
    logic                   em_we, em_store, em_taken;
    // MEM->WB
    logic [`XLEN-1:0]       mw_data;
    logic [`REG_ADDR_W-1:0] mw_rd;
    logic                   mw_we;
    logic [`XLEN-1:0]       final_q;

    assign advance         = enable_i & ~data_mem_rstb_busy_i;
    assign ins_mem_enb_o   = advance;
    assign ins_mem_addrb_o = pc;
    assign id_word         = flush_q ? '0 : ins_mem_doutb_i;   // zero word is a bubble

    decoder u_decoder (.instr_i(id_word), .dec(dec_bus));

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .rs1_i(dec_bus.rs1), .rs2_i(dec_bus.rs2),
        .wr(wb_bus), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    execute u_execute (
        .pc_i(de_pc), .rd_i(de_rd), .rs1_i(de_rs1), .rs2_i(de_rs2),
        .rs1_data_i(de_rs1_data), .rs2_data_i(de_rs2_data), .imm_i(de_imm),
        .funct3_i(de_funct3), .sub_i(de_sub),
        .is_alu_reg_i(de_alu_reg), .is_alu_imm_i(de_alu_imm), .is_lui_i(de_lui),
        .is_store_i(de_store), .is_branch_i(de_branch), .is_jal_i(de_jal),
        .fwd(wb_bus), .result_o(ex_result), .store_data_o(ex_store_data),
        .target_o(ex_target), .taken_o(ex_taken), .reg_write_o(ex_we)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= initial_pc_i;
            flush_q <= 1'b1;                    // nothing fetched yet
        end else if (advance) begin
            pc      <= em_taken ? em_target : pc + 32'd4;
            flush_q <= em_taken;                // kills the word fetched this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (reset || (advance && em_taken)) begin
            {de_alu_reg, de_alu_imm, de_lui, de_store, de_branch, de_jal} <= '0;
            {em_we, em_store, em_taken} <= '0;
        end else if (advance) begin
            de_alu_reg <= dec_bus.is_alu_reg;
            de_alu_imm <= dec_bus.is_alu_imm;
            de_lui     <= dec_bus.is_lui;
            de_store   <= dec_bus.is_store;
            de_branch  <= dec_bus.is_branch;
            de_jal     <= dec_bus.is_jal;
            em_we      <= ex_we;
            em_store   <= de_store;
            em_taken   <= ex_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mw_we   <= 1'b0;
            final_q <= '0;
        end else if (advance) begin
            mw_we <= em_we;                     // the branch itself still retires
            if (em_store)
                final_q <= em_store_data;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (advance) begin
            if_pc         <= pc;
            de_pc         <= if_pc;
            de_rd         <= dec_bus.rd;
            de_rs1        <= dec_bus.rs1;
            de_rs2        <= dec_bus.rs2;
            de_rs1_data   <= rs1_data;
            de_rs2_data   <= rs2_data;
            de_imm        <= dec_bus.imm;
            de_funct3     <= dec_bus.funct3;
            de_sub        <= dec_bus.sub;
            em_rd         <= de_rd;
            em_result     <= ex_result;
            em_store_data <= ex_store_data;
            em_target     <= ex_target;
            mw_rd         <= em_rd;
            mw_data       <= em_result;
        end
    end

    assign data_mem_enb_o   = em_store & enable_i;
    assign data_mem_web_o   = {4{data_mem_enb_o}};
    assign data_mem_addrb_o = em_result + mem_offset_i;
    assign data_mem_dinb_o  = em_store_data;
    assign final_value_o    = final_q;

    assign wb_bus.mem_rd   = em_rd;
    assign wb_bus.mem_we   = em_we;
    assign wb_bus.mem_data = em_result;
    assign wb_bus.wb_rd    = mw_rd;
    assign wb_bus.wb_we    = mw_we;
    assign wb_bus.wb_data  = mw_data;

    hold_on_busy: assert property (@(posedge clk) disable iff (reset)
        data_mem_rstb_busy_i |=> $stable({pc, flush_q, de_pc, de_store, em_result,
                                          em_store, em_taken, mw_we, mw_data}));
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- logic/riscv_top.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module riscv_top (
    input  logic              clk,
    input  logic              reset,
    input  logic [`XLEN-1:0]  ctrl_word_i,
    input  logic [`XLEN-1:0]  mem_offset_i,
    input  logic [`XLEN-1:0]  initial_pc_i,
    input  logic [`XLEN-1:0]  success_code_i,
    output logic              stop_o,
    output logic              ins_mem_enb_o,
    output logic [`XLEN-1:0]  ins_mem_addrb_o,
    input  logic [`XLEN-1:0]  ins_mem_doutb_i,
    output logic              data_mem_enb_o,
    output logic [3:0]        data_mem_web_o,
    output logic [`XLEN-1:0]  data_mem_addrb_o,
    output logic [`XLEN-1:0]  data_mem_dinb_o,
    input  logic              data_mem_rstb_busy_i
);

    logic             core_reset;
    logic             core_enable;
    logic [`XLEN-1:0] final_value;

    run_control u_run_control (
        .clk            (clk),
        .reset          (reset),
        .ctrl_word_i    (ctrl_word_i),
        .success_code_i (success_code_i),
        .final_value_i  (final_value),
        .core_reset_o   (core_reset),
        .core_enable_o  (core_enable),
        .stop_o         (stop_o)
    );

    rv_core u_core (
        .clk                  (clk),
        .reset                (core_reset),
        .enable_i             (core_enable),
        .initial_pc_i         (initial_pc_i),
        .mem_offset_i         (mem_offset_i),
        .ins_mem_enb_o        (ins_mem_enb_o),
        .ins_mem_addrb_o      (ins_mem_addrb_o),
        .ins_mem_doutb_i      (ins_mem_doutb_i),
        .data_mem_enb_o       (data_mem_enb_o),
        .data_mem_web_o       (data_mem_web_o),
        .data_mem_addrb_o     (data_mem_addrb_o),
        .data_mem_dinb_o      (data_mem_dinb_o),
        .data_mem_rstb_busy_i (data_mem_rstb_busy_i),
        .final_value_o        (final_value)
    );

endmodule

//--- testbench/riscv_tb.sv
`timescale 1ns/1ns
`include "rv_settings.svh"

module riscv_tb;

    localparam int TOTAL_LEN = 3 * 48 + 56 + 2 * 28 + 2 * 4;   // words run over all tests
    localparam logic [31:0] JAL_SELF = 32'h0000006f;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] ctrl_word, mem_offset, initial_pc, success_code;
    logic             stop;
    logic             ins_enb, data_enb, busy, busy_en;
    logic [`XLEN-1:0] ins_addr, ins_dout, data_addr, data_din;
    logic [3:0]       data_web;

    logic [31:0] imem [0:255];
    logic [31:0] got_addr[$], got_data[$], exp_addr[$], exp_data[$];
    int          plen, errors, test_errs, tests, failed;

    riscv_top UUT (
        .clk(clk), .reset(reset), .ctrl_word_i(ctrl_word), .mem_offset_i(mem_offset),
        .initial_pc_i(initial_pc), .success_code_i(success_code), .stop_o(stop),
        .ins_mem_enb_o(ins_enb), .ins_mem_addrb_o(ins_addr), .ins_mem_doutb_i(ins_dout),
        .data_mem_enb_o(data_enb), .data_mem_web_o(data_web), .data_mem_addrb_o(data_addr),
        .data_mem_dinb_o(data_din), .data_mem_rstb_busy_i(busy)
    );

    always #50 clk = ~clk;

    // instruction BRAM answers one cycle later and holds its output while disabled
    always @(posedge clk) begin
        if (ins_enb)
            ins_dout <= imem[ins_addr[9:2]];
        busy <= busy_en ? ($urandom % 3 == 0) : 1'b0;
    end

    // data port model samples on the falling edge
    always @(negedge clk) begin
        if (data_enb && data_web == 4'hf && !busy) begin
            got_addr.push_back(data_addr);
            got_data.push_back(data_din);
        end
    end

    initial begin
        #(TOTAL_LEN * 20 * 100);
        $display("watchdog expired, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
            test_errs++;
        end
    endtask

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OPIMM};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] alu_ref(logic [2:0] f3, logic sub, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            `F3_SLT: return {31'd0, $signed(a) < $signed(b)};
            `F3_XOR: return a ^ b;
            `F3_OR:  return a | b;
            `F3_AND: return a & b;
            default: return sub ? a - b : a + b;
        endcase
    endfunction

    task automatic add_word(input logic [31:0] w);
        imem[initial_pc[9:2] + plen] = w;
        plen++;
    endtask

    // x1..x7 get defined values, the register file is not reset
    task automatic prologue();
        plen = 0;
        for (int i = 1; i < 8; i++)
            add_word(enc_i(12'($urandom), 5'd0, `F3_ADD, 5'(i)));
    endtask

    task automatic gen_random(input int n, input int nregs);
        logic [2:0]  f3s [5] = '{`F3_ADD, `F3_SLT, `F3_XOR, `F3_OR, `F3_AND};
        logic [2:0]  f3;
        logic [11:0] imm;
        for (int k = 0; k < n; k++) begin
            f3  = f3s[$urandom % 5];
            imm = 12'($urandom);
            case ($urandom % 6)
                1: add_word(enc_i(imm, 5'(1 + $urandom % nregs), (f3 == `F3_SLT) ? `F3_AND : f3,
                                  5'(1 + $urandom % nregs)));
                2: add_word({20'($urandom), 5'(1 + $urandom % nregs), `OPC_LUI});
                3, 4: add_word({imm[11:5], 5'(1 + $urandom % nregs), 5'(1 + $urandom % nregs),
                                `F3_SW, imm[4:0], `OPC_STORE});
                default: add_word(enc_r((f3 == `F3_ADD && $urandom % 2) ? 7'h20 : 7'h00,
                                        5'(1 + $urandom % nregs), 5'(1 + $urandom % nregs), f3,
                                        5'(1 + $urandom % nregs), `OPC_OP));
            endcase
        end
    endtask

    // instruction set model that stops at the jump to itself
    task automatic run_iss();
        logic [31:0] r [0:31];
        logic [31:0] pc, npc, w, a, b;
        for (int i = 0; i < 32; i++)
            r[i] = '0;
        pc = initial_pc;
        exp_addr.delete();
        exp_data.delete();
        for (int steps = 0; steps < 2000; steps++) begin
            w = imem[pc[9:2]];
            if (w == JAL_SELF)
                break;
            a   = r[w[19:15]];
            b   = r[w[24:20]];
            npc = pc + 4;
            case (w[6:0])
                `OPC_OP:    r[w[11:7]] = alu_ref(w[14:12], w[30], a, b);
                `OPC_OPIMM: r[w[11:7]] = alu_ref(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
                `OPC_LUI:   r[w[11:7]] = {w[31:12], 12'd0};
                `OPC_STORE: begin
                    exp_addr.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]} + mem_offset);
                    exp_data.push_back(b);
                end
                `OPC_BRANCH: if ((a == b) ^ w[12])
                    npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                `OPC_JAL: begin
                    r[w[11:7]] = pc + 4;
                    npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                default: ;
            endcase
            r[0] = '0;
            pc   = npc;
        end
    endtask

    task automatic start_run();
        @(posedge clk);
        reset     <= 1'b1;
        ctrl_word <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_flag("fetch before start", 1'b0, ins_enb);
        end
        got_addr.delete();
        got_data.delete();
        @(posedge clk);
        ctrl_word <= 32'd1;
    endtask

    task automatic wait_stores(input int n);
        int cycles;
        cycles = 0;
        while (got_addr.size() < n && cycles < plen * 20) begin
            @(posedge clk);
            cycles++;
        end
        if (got_addr.size() < n) begin
            $display("store count %0d never reached %0d", got_addr.size(), n);
            test_errs++;
        end
        repeat (12) @(posedge clk);                  // catch stray stores
    endtask

    task automatic compare_stores(input string name);
        check_word({name, " store count"}, exp_addr.size(), got_addr.size());
        for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            check_word($sformatf("%s addr %0d", name, i), exp_addr[i], got_addr[i]);
            check_word($sformatf("%s data %0d", name, i), exp_data[i], got_data[i]);
        end
    endtask

    task automatic run_and_compare(input string name);
        add_word(JAL_SELF);
        run_iss();
        start_run();
        wait_stores(exp_addr.size());
        compare_stores(name);
    endtask

    task automatic end_test(input string name);
        tests++;
        errors += test_errs;
        if (test_errs != 0)
            failed++;
        $display("test %-16s %s (%0d errors)", name, (test_errs == 0) ? "ok" : "bad", test_errs);
        test_errs = 0;
    endtask

    initial begin
        logic [19:0] hi;
        logic [11:0] lo;
        int          waited;
        void'($urandom(32'hc12353dd));
        clk          = 0;
        reset        = 1;
        ctrl_word    = '0;
        busy         = 0;
        busy_en      = 0;
        ins_dout     = '0;
        mem_offset   = $urandom;
        initial_pc   = 32'h100;
        success_code = 32'hffff_ffff;
        errors       = 0;
        test_errs    = 0;
        tests        = 0;
        failed       = 0;
        for (int i = 0; i < 256; i++)
            imem[i] = 32'h0000_0013 | (i << 20);    // harmless ADDIs to x0

        prologue();
        gen_random(40, 7);
        run_and_compare("alu_store");
        if (exp_data.size() != 0)
            check_word("final value", exp_data[exp_data.size() - 1], UUT.final_value);
        end_test("alu_store");

        busy_en <= 1'b1;                             // same program again
        start_run();
        wait_stores(exp_addr.size());
        compare_stores("busy");
        busy_en <= 1'b0;
        end_test("busy");

        prologue();
        gen_random(40, 3);                           // three registers give dense dependences
        run_and_compare("dependences");
        end_test("dependences");

        prologue();
        for (int k = 0; k < 12; k++) begin
            logic [4:0] rs1;
            rs1 = 5'(1 + $urandom % 3);
            case ($urandom % 3)
                0: add_word(enc_b(($urandom % 2) ? 13'd8 : 13'd12, ($urandom % 2) ? rs1 : 5'd2,
                                  rs1, `F3_BEQ));
                1: add_word(enc_b(($urandom % 2) ? 13'd8 : 13'd12, ($urandom % 2) ? rs1 : 5'd3,
                                  rs1, `F3_BNE));
                default: add_word({1'b0, 10'(($urandom % 2) ? 4 : 6), 1'b0, 8'd0,
                                   5'(1 + $urandom % 3), `OPC_JAL});
            endcase
            gen_random(3, 3);
        end
        run_and_compare("branches");
        end_test("branches");

        prologue();
        gen_random(20, 7);
        run_and_compare("control_word");
        repeat (20) @(posedge clk);                  // start bit still high
        check_word("no restart", exp_addr.size(), got_addr.size());
        ctrl_word <= 32'd2;
        repeat (3) @(posedge clk);
        got_addr.delete();
        got_data.delete();
        ctrl_word <= 32'd3;
        wait_stores(exp_addr.size());
        compare_stores("rerun");
        end_test("control_word");

        hi = 20'($urandom) | 20'd1;
        lo = 12'($urandom) | 12'd1;
        success_code <= {hi, 12'd0} + {{20{lo[11]}}, lo};
        plen = 0;
        add_word({hi, 5'd1, `OPC_LUI});
        add_word(enc_i(lo, 5'd1, `F3_ADD, 5'd1));
        add_word({7'd0, 5'd1, 5'd0, `F3_SW, 5'd0, `OPC_STORE});
        run_and_compare("stop");
        waited = 0;
        while (!stop && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        if (!stop) begin
            $display("stop did not rise within 40 cycles of the success store");
            test_errs++;
        end
        success_code <= success_code ^ 32'd2;        // final value no longer matches
        repeat (10) begin
            @(negedge clk);
            check_flag("stop held", 1'b1, stop);
        end
        start_run();
        wait_stores(exp_addr.size());
        repeat (60) @(posedge clk);
        check_flag("stop on other code", 1'b0, stop);
        end_test("stop");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- build.f
+incdir+logic
logic/rv_pkg.sv
logic/core_ifs.sv
logic/decoder.sv
logic/reg_file.sv
logic/execute.sv
logic/run_control.sv
logic/rv_core.sv
logic/riscv_top.sv
testbench/riscv_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module riscv_tb -Mdir obj_dir
	out="$$(./obj_dir/Vriscv_tb)"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
